/* rtl/dcache_settings.svh */
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// cache geometry
`define DCACHE_WAYS 4
// index is addr[9:6]
`define DCACHE_SETS 16

// 32-bit beats per 64-byte line
`define LINE_BEATS 16

// backing memory, 16 KiB of 32-bit words, word index addr[13:2]
`define MEM_WORDS 4096

// word n starts out as n * this constant, kept odd so every word differs
`define MEM_INIT_MULT 32'h9e37_79b1

`endif

/* rtl/mem_pkg.sv */
package mem_pkg;

	// byte address, upper bits ignored by the memory
	typedef logic [31:0] addr_t;

	// request side data word
	typedef logic [63:0] word_t;

	// one refill beat
	typedef logic [31:0] beat_t;

	// one bit per byte of word_t
	typedef logic [7:0] byte_mask_t;

	typedef enum logic [1:0] {
		MEM_IDLE,
		MEM_GAP,
		MEM_BURST
	} mem_state_e;

endpackage

/* rtl/dcache_pkg.sv */
`include "dcache_settings.svh"

package dcache_pkg;

	// addr[31:10]
	typedef logic [21:0] tag_t;

	// addr[9:6]
	typedef logic [3:0] index_t;

	// set index plus row inside the line, addr[9:4]
	typedef logic [5:0] row_t;

	// one bit per way
	typedef logic [`DCACHE_WAYS-1:0] way_mask_t;

	// one data ram row, four 32-bit lanes
	typedef logic [127:0] line_row_t;

	typedef enum logic {
		LOOKUP,
		REFILL
	} ctrl_state_e;

endpackage

/* rtl/dcache_ifs.sv */
`timescale 1ns/1ns
`include "dcache_settings.svh"

// line refill channel between cache and memory
interface refill_if import mem_pkg::*; ();
	addr_t araddr;
	logic  arvalid;
	logic  arready;
	beat_t rdata;
	logic  rvalid;
	logic  rlast;

	modport memory (input araddr, arvalid, output arready, rdata, rvalid, rlast);
	modport cache (output araddr, arvalid, input arready, rdata, rvalid, rlast);
endinterface

// write-through path, one masked 64-bit word per cycle
interface mem_wr_if import mem_pkg::*; ();
	logic       we;
	addr_t      waddr;
	word_t      wdata;
	byte_mask_t wmask;

	modport memory (input we, waddr, wdata, wmask);
	modport cache (output we, waddr, wdata, wmask);
endinterface

// data ram port shared by all ways
interface way_ram_if import mem_pkg::*, dcache_pkg::*; ();
	way_mask_t ce;
	logic      we;
	row_t      row;
	logic [1:0] lane;
	beat_t     wdata;
	line_row_t [`DCACHE_WAYS-1:0] rdata;

	modport storage (input ce, we, row, lane, wdata, output rdata);
	modport control (output ce, we, row, lane, wdata, input rdata);
endinterface

/* rtl/burst_mem.sv */
`timescale 1ns/1ns
`include "dcache_settings.svh"

module burst_mem import mem_pkg::*; (
	input logic clk,
	input logic rst,
	refill_if.memory rf,
	mem_wr_if.memory wr
);

	localparam int WORD_W = $clog2(`MEM_WORDS);
	localparam int BEAT_W = $clog2(`LINE_BEATS);

	beat_t mem [`MEM_WORDS];

	mem_state_e state;
	logic [BEAT_W-1:0] beat_cnt;
	// line number of the burst in progress
	logic [WORD_W-BEAT_W-1:0] base;

	initial begin
		for (int n = 0; n < `MEM_WORDS; n++) begin
			mem[n] = beat_t'(n) * `MEM_INIT_MULT;
		end
	end

	// masked write of two consecutive words, low word takes bytes 0..3
	always @(posedge clk) begin
		if (wr.we) begin
			for (int b = 0; b < 8; b++) begin
				if (wr.wmask[b]) begin
					mem[{wr.waddr[WORD_W+1:3], 1'(b / 4)}][(b % 4)*8 +: 8] <= wr.wdata[b*8 +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= MEM_IDLE;
			beat_cnt <= '0;
		end else begin
			case (state)
				MEM_IDLE: begin
					beat_cnt <= '0;
					if (rf.arvalid && rf.arready) begin
						state <= MEM_GAP;
					end
				end
				// one dead cycle before the first beat
				MEM_GAP: state <= MEM_BURST;
				MEM_BURST: begin
					beat_cnt <= beat_cnt + 1'b1;
					if (rf.rlast) begin
						state <= MEM_IDLE;
					end
				end
				default: state <= MEM_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == MEM_IDLE && rf.arvalid) begin
			base <= rf.araddr[WORD_W+1:BEAT_W+2];
		end
	end

	assign rf.arready = (state == MEM_IDLE);
	assign rf.rvalid = (state == MEM_BURST);
	assign rf.rlast = rf.rvalid && (beat_cnt == BEAT_W'(`LINE_BEATS - 1));
	assign rf.rdata = mem[{base, beat_cnt}];

endmodule

/* rtl/way_data_ram.sv */
`timescale 1ns/1ns
`include "dcache_settings.svh"

module way_data_ram import dcache_pkg::*; (
	input logic clk,
	way_ram_if.storage ram
);

	// four 128-bit rows per 64-byte line
	localparam int ROWS = `DCACHE_SETS * (`LINE_BEATS / 4);

	line_row_t data [`DCACHE_WAYS][ROWS];

	// written lane of the addressed row
	function automatic line_row_t merge_lane(
		input line_row_t old_row,
		input logic [1:0] lane,
		input logic [31:0] value
	);
		line_row_t r;
		r = old_row;
		r[lane*32 +: 32] = value;
		return r;
	endfunction

	// one 32-bit lane per enabled way
	always_ff @(posedge clk) begin
		for (int w = 0; w < `DCACHE_WAYS; w++) begin
			if (ram.ce[w] && ram.we) begin
				data[w][ram.row] <= merge_lane(data[w][ram.row], ram.lane, ram.wdata);
			end
		end
	end

	// registered read of the enabled ways
	always_ff @(posedge clk) begin
		for (int w = 0; w < `DCACHE_WAYS; w++) begin
			if (ram.ce[w] && !ram.we) begin
				ram.rdata[w] <= data[w][ram.row];
			end
		end
	end

endmodule

/* rtl/dcache_ctrl.sv */
`timescale 1ns/1ns
`include "dcache_settings.svh"

module dcache_ctrl import mem_pkg::*, dcache_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       valid,
	input  logic       wren,
	input  addr_t      addr,
	input  word_t      din,
	input  byte_mask_t mask,
	output logic       ready,
	output word_t      dout,
	refill_if.cache    rf,
	mem_wr_if.cache    wr,
	way_ram_if.control ram
);

	localparam int BEAT_W = $clog2(`LINE_BEATS);

	ctrl_state_e state;

	tag_t tags [`DCACHE_WAYS][`DCACHE_SETS];
	logic [`DCACHE_SETS-1:0] vld [`DCACHE_WAYS];

	index_t idx;
	tag_t tag;
	way_mask_t hit_mask;
	way_mask_t hit_q;
	way_mask_t victim;
	logic [BEAT_W-1:0] beat_cnt;
	line_row_t line_sel;

	logic take;
	logic rd_hit;
	logic rd_miss;
	logic wr_go;
	logic fill_done;

	assign idx = addr[9:6];
	assign tag = addr[31:10];

	always_comb begin
		for (int w = 0; w < `DCACHE_WAYS; w++) begin
			hit_mask[w] = vld[w][idx] && (tags[w][idx] == tag);
		end
	end

	// valid is ignored while ready is up
	assign take = (state == LOOKUP) && valid && !ready;
	assign rd_hit = take && !wren && (hit_mask != '0);
	assign rd_miss = take && !wren && (hit_mask == '0);
	assign wr_go = take && wren;
	assign fill_done = (state == REFILL) && rf.rvalid && rf.rlast;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= LOOKUP;
		end else begin
			case (state)
				LOOKUP: if (rd_miss && rf.arready) state <= REFILL;
				REFILL: if (fill_done) state <= LOOKUP;
				default: state <= LOOKUP;
			endcase
		end
	end

	// beat counter and round-robin victim
	always_ff @(posedge clk) begin
		if (rst) begin
			beat_cnt <= '0;
			victim <= way_mask_t'(1);
		end else if (state == LOOKUP) begin
			beat_cnt <= '0;
			victim <= {victim[`DCACHE_WAYS-2:0], victim[`DCACHE_WAYS-1]};
		end else if (rf.rvalid) begin
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		for (int w = 0; w < `DCACHE_WAYS; w++) begin
			if (fill_done && victim[w]) begin
				tags[w][idx] <= tag;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < `DCACHE_WAYS; w++) begin
				vld[w] <= '0;
			end
		end else begin
			for (int w = 0; w < `DCACHE_WAYS; w++) begin
				if (fill_done && victim[w]) begin
					vld[w][idx] <= 1'b1;
				end else if (wr_go && hit_mask[w]) begin
					// write-through drops the stale copy
					vld[w][idx] <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ready <= 1'b0;
			hit_q <= '0;
		end else begin
			ready <= rd_hit || wr_go;
			hit_q <= rd_hit ? hit_mask : '0;
		end
	end

	assign rf.arvalid = rd_miss;
	assign rf.araddr = {addr[31:6], 6'b0};

	assign wr.we = wr_go;
	assign wr.waddr = addr;
	assign wr.wdata = din;
	assign wr.wmask = mask;

	// lookup reads the hit way, refill writes the victim lane by lane
	assign ram.ce = (state == LOOKUP) ? (rd_hit ? hit_mask : '0) : (rf.rvalid ? victim : '0);
	assign ram.we = (state == REFILL) && rf.rvalid;
	assign ram.row = (state == LOOKUP) ? addr[9:4] : {idx, beat_cnt[BEAT_W-1:BEAT_W-2]};
	assign ram.lane = beat_cnt[1:0];
	assign ram.wdata = rf.rdata;

	always_comb begin
		line_sel = '0;
		for (int w = 0; w < `DCACHE_WAYS; w++) begin
			if (hit_q[w]) begin
				line_sel = ram.rdata[w];
			end
		end
	end

	// addr[3] picks the 64-bit half
	assign dout = addr[3] ? line_sel[127:64] : line_sel[63:0];

endmodule

/* rtl/dcache_top.sv */
`timescale 1ns/1ns

module dcache_top import mem_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       valid,
	input  logic       wren,
	input  addr_t      addr,
	input  word_t      din,
	input  byte_mask_t mask,
	output logic       ready,
	output word_t      dout
);

	refill_if rf_bus ();
	mem_wr_if wr_bus ();
	way_ram_if ram_bus ();

	// backing store, refill bursts and write-through
	burst_mem u_mem (
		.clk (clk),
		.rst (rst),
		.rf  (rf_bus.memory),
		.wr  (wr_bus.memory)
	);

	way_data_ram u_ram (
		.clk (clk),
		.ram (ram_bus.storage)
	);

	dcache_ctrl u_ctrl (
		.clk   (clk),
		.rst   (rst),
		.valid (valid),
		.wren  (wren),
		.addr  (addr),
		.din   (din),
		.mask  (mask),
		.ready (ready),
		.dout  (dout),
		.rf    (rf_bus.cache),
		.wr    (wr_bus.cache),
		.ram   (ram_bus.control)
	);

endmodule

/* sim/dcache_checker.sv */
`timescale 1ns/1ns

module dcache_checker import mem_pkg::*, dcache_pkg::*; (
	input logic        clk,
	input logic        rst,
	input logic        ready,
	input way_mask_t   hit_mask,
	input logic        rvalid,
	input logic        rlast,
	input logic        arvalid,
	input ctrl_state_e state
);

	// one-cycle ready pulse per request
	a_ready_pulse: assert property (@(posedge clk) disable iff (rst) ready |=> !ready)
		else $error("ready held high on two consecutive cycles");

	// at most one way can hold a given tag
	a_hit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(hit_mask))
		else $error("hit mask has more than one way set");

	a_rlast_rvalid: assert property (@(posedge clk) disable iff (rst) rlast |-> rvalid)
		else $error("rlast seen without rvalid");

	// no new line request while a burst is in flight
	a_no_ar_in_refill: assert property (@(posedge clk) disable iff (rst)
		(state == REFILL) |-> !arvalid)
		else $error("arvalid raised during refill");

endmodule

bind dcache_ctrl dcache_checker u_checker (
	.clk      (clk),
	.rst      (rst),
	.ready    (ready),
	.hit_mask (hit_mask),
	.rvalid   (rf.rvalid),
	.rlast    (rf.rlast),
	.arvalid  (rf.arvalid),
	.state    (state)
);

/* sim/dcache_tb.sv */
`timescale 1ns/1ns
`include "dcache_settings.svh"

module dcache_tb import mem_pkg::*; ();

	localparam int MAX_REQUESTS = 400;
	localparam int REQ_CYCLES = 20;
	// reset and slack on top of the request budget
	localparam int TIMEOUT_CYCLES = MAX_REQUESTS * REQ_CYCLES + 2000;

	logic clk, rst, valid, wren, ready;
	addr_t addr;
	word_t din, dout;
	byte_mask_t mask;
	beat_t shadow [`MEM_WORDS];
	int cycle_count = 0;

	dcache_top u_dut (
		.clk (clk), .rst (rst), .valid (valid), .wren (wren), .addr (addr),
		.din (din), .mask (mask), .ready (ready), .dout (dout)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("*** TEST FAILED ***");
		$fatal(1, "%s", why);
	endtask

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			abort_run("run took too many cycles, the cache seems stuck");
		end
	end

	// expected 64-bit word from the shadow copy
	function automatic word_t shadow_word(input addr_t a);
		return {shadow[{a[13:3], 1'b1}], shadow[{a[13:3], 1'b0}]};
	endfunction

	function automatic void shadow_write(input addr_t a, input word_t d, input byte_mask_t m);
		logic [11:0] wi;
		for (int b = 0; b < 8; b++) begin
			wi = {a[13:3], 1'(b / 4)};
			if (m[b]) shadow[wi][(b % 4) * 8 +: 8] = d[b * 8 +: 8];
		end
	endfunction

	task automatic check_word(input word_t expected, input word_t actual, input string name);
		if (actual !== expected) begin
			$display("FAILED %s expected 0x%h actual 0x%h", name, expected, actual);
			abort_run("read data does not match the memory contents");
		end
	endtask

	task automatic check_latency(input int lat, input bit hit_expected);
		int expected;
		expected = hit_expected ? 1 : 19;
		if (lat != expected) begin
			abort_run($sformatf("expected a %s taking %0d cycles but ready came after %0d",
				hit_expected ? "hit" : "miss", expected, lat));
		end
	endtask

	// one request, valid held until ready, dout sampled on the falling edge
	task automatic request(input logic w, input addr_t a, input word_t d, input byte_mask_t m,
			output word_t rdata, output int lat);
		bit seen;
		@(negedge clk);
		valid = 1'b1;
		wren = w;
		addr = a;
		din = d;
		mask = m;
		lat = 0;
		seen = 1'b0;
		while (!seen && lat < REQ_CYCLES) begin
			@(negedge clk);
			lat++;
			if (ready) seen = 1'b1;
		end
		rdata = dout;
		valid = 1'b0;
		wren = 1'b0;
		if (!seen) begin
			abort_run($sformatf("no ready within %0d cycles of valid", REQ_CYCLES));
		end else if (lat != 1 && lat != 19) begin
			abort_run($sformatf("ready came after %0d cycles, neither a hit nor a miss", lat));
		end
	endtask

	task automatic read_check(input addr_t a, output int lat);
		word_t got;
		request(1'b0, a, '0, '0, got, lat);
		check_word(shadow_word(a), got, "dout");
	endtask

	task automatic write_word(input addr_t a, input word_t d, input byte_mask_t m, output int lat);
		word_t unused_rd;
		request(1'b1, a, d, m, unused_rd, lat);
		shadow_write(a, d, m);
	endtask

	// distinct sets, so nothing gets evicted
	task automatic cold_then_warm_reads();
		addr_t list [4] = '{32'h0000, 32'h0448, 32'h1a90, 32'h3ff8};
		int lat;
		foreach (list[i]) begin
			read_check(list[i], lat);
			check_latency(lat, 1'b0);
		end
		foreach (list[i]) begin
			read_check(list[i], lat);
			check_latency(lat, 1'b1);
		end
	endtask

	task automatic full_line_read();
		int lat;
		read_check(32'h02c0, lat);
		check_latency(lat, 1'b0);
		for (int k = 0; k < 8; k++) begin
			read_check(addr_t'(32'h02c0 + k * 8), lat);
			check_latency(lat, 1'b1);
		end
	endtask

	task automatic partial_write_merge();
		int lat;
		read_check(32'h0448, lat);
		check_latency(lat, 1'b1);
		write_word(32'h0448, 64'hdead_beef_0bad_f00d, 8'b0110_0101, lat);
		check_latency(lat, 1'b1);
		// the write dropped the cached copy
		read_check(32'h0448, lat);
		check_latency(lat, 1'b0);
	endtask

	// five tags in set 5, one more than the ways
	task automatic set_conflict_reads();
		int lat;
		for (int k = 0; k < 5; k++) begin
			read_check(addr_t'(32'h0140 + k * 32'h0408), lat);
			check_latency(lat, 1'b0);
		end
		for (int k = 0; k < 5; k++) begin
			read_check(addr_t'(32'h0140 + k * 32'h0408), lat);
		end
	endtask

	task automatic random_traffic();
		int line, word, lat;
		addr_t a;
		for (int i = 0; i < 300; i++) begin
			// every 4th line, so four sets see heavy conflict
			line = int'($urandom % 64) * 4;
			word = int'($urandom % 8);
			a = addr_t'(line * 64 + word * 8);
			if ($urandom % 3 == 0) begin
				write_word(a, {$urandom, $urandom}, byte_mask_t'($urandom), lat);
				check_latency(lat, 1'b1);
			end else begin
				read_check(a, lat);
			end
		end
	endtask

	initial begin
		void'($urandom(11));
		rst = 1'b1;
		valid = 1'b0;
		wren = 1'b0;
		addr = '0;
		din = '0;
		mask = '0;
		for (int n = 0; n < `MEM_WORDS; n++) begin
			shadow[n] = beat_t'(n) * `MEM_INIT_MULT;
		end
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		cold_then_warm_reads();
		full_line_read();
		partial_write_merge();
		set_conflict_reads();
		random_traffic();
		repeat (2) @(negedge clk);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

/* sources.f */
+incdir+rtl
rtl/mem_pkg.sv
rtl/dcache_pkg.sv
rtl/dcache_ifs.sv
rtl/burst_mem.sv
rtl/way_data_ram.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
sim/dcache_checker.sv
sim/dcache_tb.sv

/* Makefile */
TOP = dcache_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
